/* data_ram.sv */
`timescale 1ns/1ps

module data_ram import dcache_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  req,
    input  logic  wr,
    input  size_t size,
    input  word_t addr,
    input  word_t wdata,
    output logic  addr_ok,
    output logic  data_ok,
    output word_t rdata
);

    word_t mem_q [2**ram_addr_width];

    logic busy_q;
    logic [lat_width-1:0] count_q;
    logic [ram_addr_width-1:0] word_addr;
    be_t be;

    // upper address bits wrap onto the RAM
    assign word_addr = addr[offset_width +: ram_addr_width];
    assign be = byte_mask(size, addr[offset_width-1:0]);

    // one access in flight at a time
    assign addr_ok = req && !busy_q;
    assign data_ok = busy_q && (count_q == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
            count_q <= '0;
        end else if (addr_ok) begin
            busy_q <= 1'b1;
            count_q <= lat_width'(mem_latency - 1);
        end else if (data_ok) begin
            busy_q <= 1'b0;
        end else if (busy_q) begin
            count_q <= count_q - lat_width'(1);
        end
    end

    // write lanes and read word are both taken at acceptance
    always_ff @(posedge clk) begin
        if (addr_ok) begin
            if (wr) begin
                for (int i = 0; i < 4; i++) begin
                    if (be[i]) begin
                        mem_q[word_addr][8*i +: 8] <= wdata[8*i +: 8];
                    end
                end
            end else begin
                rdata <= mem_q[word_addr];
            end
        end
    end

endmodule

/* dcache_ctrl.sv */
`timescale 1ns/1ps

module dcache_ctrl import dcache_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   cpu_req,
    input  logic   cpu_wr,
    input  word_t  cpu_addr,
    input  logic   hit,
    input  logic   data_except,
    input  logic   mem_addr_ok,
    input  logic   mem_data_ok,
    output logic   cpu_addr_ok,
    output logic   cpu_data_ok,
    output logic   mem_req,
    output logic   wr_hit_en,
    output logic   fill_en,
    output index_t fill_index,
    output tag_t   fill_tag
);

    cache_state_e state_q;
    cache_state_e state_d;
    guard_state_e guard_q;
    guard_state_e guard_d;
    logic addr_rcv_q;
    logic read_hit;
    logic fill_blocked;
    index_t index_q;
    tag_t tag_q;

    // read hit answers in the request cycle
    assign read_hit = (state_q == idle) && cpu_req && !cpu_wr && hit;

    always_comb begin
        state_d = state_q;
        case (state_q)
            idle: begin
                if (cpu_req && cpu_wr) begin
                    state_d = write_mem;
                end else if (cpu_req && !hit) begin
                    state_d = read_mem;
                end
            end
            read_mem, write_mem: begin
                if (mem_data_ok) begin
                    state_d = idle;
                end
            end
            default: state_d = idle;
        endcase
    end

    // guard covers the faulting refill and the one after it
    always_comb begin
        guard_d = guard_q;
        case (guard_q)
            guard_idle: begin
                if (data_except) begin
                    guard_d = guard_first;
                end
            end
            guard_first: begin
                if (mem_data_ok) begin
                    guard_d = guard_second;
                end
            end
            guard_second: begin
                if (mem_data_ok) begin
                    guard_d = guard_idle;
                end
            end
            default: guard_d = guard_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= idle;
            guard_q <= guard_idle;
            addr_rcv_q <= 1'b0;
        end else begin
            state_q <= state_d;
            guard_q <= guard_d;
            if (mem_req && mem_addr_ok) begin
                addr_rcv_q <= 1'b1;
            end else if (mem_data_ok) begin
                addr_rcv_q <= 1'b0;
            end
        end
    end

    // refill target, held steady while the request is up
    always_ff @(posedge clk) begin
        if (cpu_req) begin
            index_q <= cpu_addr[offset_width +: index_width];
            tag_q <= cpu_addr[offset_width + index_width +: tag_width];
        end
    end

    assign fill_blocked = (guard_q != guard_idle);

    // drop the request once the RAM took the address
    assign mem_req = (state_q != idle) && !addr_rcv_q;

    assign wr_hit_en = (state_q == idle) && cpu_req && cpu_wr && hit;
    assign fill_en = (state_q == read_mem) && mem_data_ok && !fill_blocked;
    assign fill_index = index_q;
    assign fill_tag = tag_q;

    assign cpu_addr_ok = read_hit || (mem_req && mem_addr_ok);
    assign cpu_data_ok = read_hit || mem_data_ok;

endmodule

/* dcache_pkg.sv */
package dcache_pkg;

    // address split into tag, index and byte offset
    localparam int offset_width = 2;
    localparam int index_width = 10;
    localparam int tag_width = 32 - index_width - offset_width;
    localparam int cache_depth = 1 << index_width;

    // backing data RAM
    localparam int ram_addr_width = 12;
    localparam int mem_latency = 3;
    // wide enough to count down from mem_latency - 1
    localparam int lat_width = $clog2(mem_latency + 1);

    typedef logic [31:0] word_t;
    typedef logic [tag_width-1:0] tag_t;
    typedef logic [index_width-1:0] index_t;
    typedef logic [1:0] size_t;
    typedef logic [3:0] be_t;

    typedef enum logic [1:0] {
        idle,
        read_mem,
        write_mem
    } cache_state_e;

    typedef enum logic [1:0] {
        guard_idle,
        guard_first,
        guard_second
    } guard_state_e;

    // byte lanes touched by an access of the given size and offset
    function automatic be_t byte_mask(input size_t size, input logic [1:0] low);
        be_t mask;
        case (size)
            2'd0: mask = be_t'(1) << low;
            2'd1: mask = low[1] ? 4'b1100 : 4'b0011;
            default: mask = 4'b1111;
        endcase
        return mask;
    endfunction

endpackage

/* dcache_store.sv */
`timescale 1ns/1ps

module dcache_store import dcache_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  word_t  lookup_addr,
    input  logic   no_dcache,
    input  logic   wr_hit_en,
    input  size_t  wr_size,
    input  word_t  wr_data,
    input  logic   fill_en,
    input  index_t fill_index,
    input  tag_t   fill_tag,
    input  word_t  fill_data,
    output logic   hit,
    output word_t  line_data
);

    logic [cache_depth-1:0] valid_q;
    tag_t tag_q [cache_depth];
    word_t data_q [cache_depth];

    index_t lookup_index;
    tag_t lookup_tag;
    be_t wr_be;
    word_t merged;

    assign lookup_index = lookup_addr[offset_width +: index_width];
    assign lookup_tag = lookup_addr[offset_width + index_width +: tag_width];

    // uncached accesses never hit, even on a matching line
    assign hit = valid_q[lookup_index] && (tag_q[lookup_index] == lookup_tag) && !no_dcache;
    assign line_data = data_q[lookup_index];

    assign wr_be = byte_mask(wr_size, lookup_addr[offset_width-1:0]);

    // store data already sits in its byte lanes
    always_comb begin
        merged = line_data;
        for (int i = 0; i < 4; i++) begin
            if (wr_be[i]) begin
                merged[8*i +: 8] = wr_data[8*i +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (fill_en) begin
            valid_q[fill_index] <= 1'b1;
        end
    end

    // refill uses the saved index, a write hit the live one
    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_q[fill_index] <= fill_tag;
            data_q[fill_index] <= fill_data;
        end else if (wr_hit_en) begin
            data_q[lookup_index] <= merged;
        end
    end

endmodule

/* dcache_wt.sv */
`timescale 1ns/1ps

module dcache_wt import dcache_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    // processor side
    input  logic  cpu_req,
    input  logic  cpu_wr,
    input  size_t cpu_size,
    input  word_t cpu_addr,
    input  word_t cpu_wdata,
    input  logic  no_dcache,
    input  logic  data_except,
    output logic  cpu_addr_ok,
    output logic  cpu_data_ok,
    output word_t cpu_rdata,
    // memory side
    output logic  mem_req,
    output logic  mem_wr,
    output size_t mem_size,
    output word_t mem_addr,
    output word_t mem_wdata,
    input  logic  mem_addr_ok,
    input  logic  mem_data_ok,
    input  word_t mem_rdata
);

    logic hit;
    word_t line_data;
    logic wr_hit_en;
    logic fill_en;
    index_t fill_index;
    tag_t fill_tag;

    dcache_ctrl i_ctrl (
        .clk         (clk),
        .rst         (rst),
        .cpu_req     (cpu_req),
        .cpu_wr      (cpu_wr),
        .cpu_addr    (cpu_addr),
        .hit         (hit),
        .data_except (data_except),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .cpu_addr_ok (cpu_addr_ok),
        .cpu_data_ok (cpu_data_ok),
        .mem_req     (mem_req),
        .wr_hit_en   (wr_hit_en),
        .fill_en     (fill_en),
        .fill_index  (fill_index),
        .fill_tag    (fill_tag)
    );

    dcache_store i_store (
        .clk         (clk),
        .rst         (rst),
        .lookup_addr (cpu_addr),
        .no_dcache   (no_dcache),
        .wr_hit_en   (wr_hit_en),
        .wr_size     (cpu_size),
        .wr_data     (cpu_wdata),
        .fill_en     (fill_en),
        .fill_index  (fill_index),
        .fill_tag    (fill_tag),
        .fill_data   (mem_rdata),
        .hit         (hit),
        .line_data   (line_data)
    );

    // write-through, so the access goes out unchanged
    assign mem_wr = cpu_wr;
    assign mem_size = cpu_size;
    assign mem_addr = cpu_addr;
    assign mem_wdata = cpu_wdata;

    assign cpu_rdata = hit ? line_data : mem_rdata;

endmodule

/* dmem_subsys.sv */
`timescale 1ns/1ps

module dmem_subsys import dcache_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  cpu_req,
    input  logic  cpu_wr,
    input  size_t cpu_size,
    input  word_t cpu_addr,
    input  word_t cpu_wdata,
    input  logic  no_dcache,
    input  logic  data_except,
    output logic  cpu_addr_ok,
    output logic  cpu_data_ok,
    output word_t cpu_rdata
);

    // cache to RAM
    logic mem_req;
    logic mem_wr;
    size_t mem_size;
    word_t mem_addr;
    word_t mem_wdata;
    logic mem_addr_ok;
    logic mem_data_ok;
    word_t mem_rdata;

    dcache_wt i_cache (
        .clk         (clk),
        .rst         (rst),
        .cpu_req     (cpu_req),
        .cpu_wr      (cpu_wr),
        .cpu_size    (cpu_size),
        .cpu_addr    (cpu_addr),
        .cpu_wdata   (cpu_wdata),
        .no_dcache   (no_dcache),
        .data_except (data_except),
        .cpu_addr_ok (cpu_addr_ok),
        .cpu_data_ok (cpu_data_ok),
        .cpu_rdata   (cpu_rdata),
        .mem_req     (mem_req),
        .mem_wr      (mem_wr),
        .mem_size    (mem_size),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .mem_rdata   (mem_rdata)
    );

    data_ram i_ram (
        .clk     (clk),
        .rst     (rst),
        .req     (mem_req),
        .wr      (mem_wr),
        .size    (mem_size),
        .addr    (mem_addr),
        .wdata   (mem_wdata),
        .addr_ok (mem_addr_ok),
        .data_ok (mem_data_ok),
        .rdata   (mem_rdata)
    );

endmodule

/* dmem_subsys_assert.sv */
`timescale 1ns/1ps

module dmem_subsys_assert (
    input logic clk,
    input logic rst,
    input logic cpu_req,
    input logic cpu_data_ok,
    input logic mem_req,
    input logic mem_addr_ok,
    input logic mem_data_ok
);

    // RAM holds an accepted access until data_ok
    logic in_flight_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            in_flight_q <= 1'b0;
        end else if (mem_req && mem_addr_ok) begin
            in_flight_q <= 1'b1;
        end else if (mem_data_ok) begin
            in_flight_q <= 1'b0;
        end
    end

    req_drops: assert property (@(posedge clk) disable iff (rst)
        mem_req && mem_addr_ok |=> !mem_req)
        else $error("mem_req still high after mem_addr_ok");

    data_needs_req: assert property (@(posedge clk) disable iff (rst)
        cpu_data_ok |-> cpu_req)
        else $error("cpu_data_ok without a processor request");

    single_outstanding: assert property (@(posedge clk) disable iff (rst)
        in_flight_q && !mem_data_ok |-> !mem_req)
        else $error("new mem_req before mem_data_ok");

endmodule

bind dcache_wt dmem_subsys_assert i_assert (
    .clk         (clk),
    .rst         (rst),
    .cpu_req     (cpu_req),
    .cpu_data_ok (cpu_data_ok),
    .mem_req     (mem_req),
    .mem_addr_ok (mem_addr_ok),
    .mem_data_ok (mem_data_ok)
);

/* files.f */
dcache_pkg.sv
dcache_store.sv
dcache_ctrl.sv
dcache_wt.sv
data_ram.sv
dmem_subsys.sv
dmem_subsys_assert.sv
tb_dmem_subsys.sv

/* run.sh */
#!/bin/sh
# build and run the dmem_subsys testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -j 0 --top-module tb_dmem_subsys -f files.f -o tb_dmem_subsys
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/tb_dmem_subsys > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
    echo "test failed"
    exit 1
fi

if ! grep -q "ALL CHECKS PASSED" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi

echo "test passed"
exit 0

/* tb_dmem_subsys.sv */
`timescale 1ns/1ps

module tb_dmem_subsys import dcache_pkg::*; ();

    logic clk;
    logic rst;
    logic cpu_req;
    logic cpu_wr;
    size_t cpu_size;
    word_t cpu_addr;
    word_t cpu_wdata;
    logic no_dcache;
    logic data_except;
    logic cpu_addr_ok;
    logic cpu_data_ok;
    word_t cpu_rdata;

    // reference model of RAM and cache
    word_t ref_mem [2**ram_addr_width];
    logic ref_valid [cache_depth];
    tag_t ref_tag [cache_depth];
    word_t ref_data [cache_depth];
    int guard_left;

    // expectations handed to the checker, one entry per access
    int exp_lat_q [$];
    logic exp_chk_q [$];
    word_t exp_data_q [$];

    logic [31:0] lcg_state;
    int lat_cnt;
    int addr_ok_cnt;
    int chk_lat;
    logic chk_data;
    word_t chk_word;

    dmem_subsys i_dmem_subsys (
        .clk         (clk),
        .rst         (rst),
        .cpu_req     (cpu_req),
        .cpu_wr      (cpu_wr),
        .cpu_size    (cpu_size),
        .cpu_addr    (cpu_addr),
        .cpu_wdata   (cpu_wdata),
        .no_dcache   (no_dcache),
        .data_except (data_except),
        .cpu_addr_ok (cpu_addr_ok),
        .cpu_data_ok (cpu_data_ok),
        .cpu_rdata   (cpu_rdata)
    );

    always #10 clk = ~clk;

    task automatic report_fail(input string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // lanes covered by a store of 1, 2 or 4 bytes, aligned down to its size
    function automatic logic [3:0] lanes_for(input size_t size, input logic [1:0] off);
        int nbytes;
        int first_lane;
        logic [3:0] lanes;
        case (size)
            2'd0: nbytes = 1;
            2'd1: nbytes = 2;
            default: nbytes = 4;
        endcase
        first_lane = (int'(off) / nbytes) * nbytes;
        for (int b = 0; b < 4; b++) begin
            lanes[b] = (b >= first_lane) && (b < first_lane + nbytes);
        end
        return lanes;
    endfunction

    function automatic word_t merge_lanes(input word_t old, input word_t wdata,
                                          input logic [3:0] lanes);
        word_t res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (lanes[b]) begin
                res[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return res;
    endfunction

    // expected read word, and whether the access should hit
    function automatic word_t expect_read(input word_t addr, input logic unc,
                                          output logic exp_hit);
        logic [9:0] idx;
        idx = addr[11:2];
        exp_hit = !unc && ref_valid[idx] && (ref_tag[idx] == addr[31:12]);
        if (exp_hit) begin
            return ref_data[idx];
        end
        return ref_mem[addr[13:2]];
    endfunction

    function automatic void update_model(input logic wr, input size_t size, input word_t addr,
                                         input word_t wdata, input logic was_hit);
        logic [11:0] waddr;
        logic [9:0] idx;
        logic [3:0] lanes;
        waddr = addr[13:2];
        idx = addr[11:2];
        lanes = lanes_for(size, addr[1:0]);
        if (wr) begin
            ref_mem[waddr] = merge_lanes(ref_mem[waddr], wdata, lanes);
            if (was_hit) begin
                ref_data[idx] = merge_lanes(ref_data[idx], wdata, lanes);
            end
        end
        // every RAM round trip uses up one guarded refill
        if (wr || !was_hit) begin
            if (guard_left > 0) begin
                guard_left = guard_left - 1;
            end else if (!wr) begin
                ref_valid[idx] = 1'b1;
                ref_tag[idx] = addr[31:12];
                ref_data[idx] = ref_mem[waddr];
            end
        end
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic do_access(input logic wr, input size_t size, input word_t addr,
                             input word_t wdata, input logic unc);
        logic exp_hit;
        word_t exp_word;
        int waited;
        exp_word = expect_read(addr, unc, exp_hit);
        exp_lat_q.push_back((exp_hit && !wr) ? 0 : 1 + mem_latency);
        exp_chk_q.push_back(!wr);
        exp_data_q.push_back(exp_word);
        cpu_req = 1'b1;
        cpu_wr = wr;
        cpu_size = size;
        cpu_addr = addr;
        cpu_wdata = wdata;
        no_dcache = unc;
        waited = 0;
        @(negedge clk);
        while (!cpu_data_ok) begin
            waited = waited + 1;
            if (waited >= 20) begin
                report_fail($sformatf("timeout: no cpu_data_ok within 20 cycles at %h", addr));
            end
            @(negedge clk);
        end
        update_model(wr, size, addr, wdata, exp_hit);
        @(posedge clk);
        #1;
        cpu_req = 1'b0;
        cpu_wr = 1'b0;
        no_dcache = 1'b0;
    endtask

    task automatic pulse_except();
        data_except = 1'b1;
        if (guard_left == 0) begin
            guard_left = 2;
        end
        @(posedge clk);
        #1;
        data_except = 1'b0;
    endtask

    task automatic write_then_read(input word_t a);
        do_access(1'b1, 2'd2, a, lcg_next(), 1'b0);
        do_access(1'b0, 2'd2, a, '0, 1'b0);
        do_access(1'b0, 2'd2, a, '0, 1'b0);
    endtask

    // p gets cached first, q stays out of the cache until read
    task automatic partial_lane_writes(input word_t p, input word_t q);
        do_access(1'b1, 2'd2, p, lcg_next(), 1'b0);
        do_access(1'b0, 2'd2, p, '0, 1'b0);
        do_access(1'b1, 2'd2, q, lcg_next(), 1'b0);
        for (int off = 0; off < 4; off++) begin
            do_access(1'b1, 2'd0, p + word_t'(off), lcg_next(), 1'b0);
            do_access(1'b1, 2'd0, q + word_t'(off), lcg_next(), 1'b0);
            do_access(1'b0, 2'd2, p, '0, 1'b0);
        end
        for (int off = 0; off < 4; off += 2) begin
            do_access(1'b1, 2'd1, p + word_t'(off), lcg_next(), 1'b0);
            do_access(1'b1, 2'd1, q + word_t'(off), lcg_next(), 1'b0);
        end
        do_access(1'b0, 2'd2, p, '0, 1'b0);
        do_access(1'b0, 2'd2, q, '0, 1'b0);
        do_access(1'b0, 2'd2, q, '0, 1'b0);
    endtask

    task automatic conflict_eviction(input word_t a, input word_t b);
        do_access(1'b1, 2'd2, a, lcg_next(), 1'b0);
        do_access(1'b1, 2'd2, b, lcg_next(), 1'b0);
        do_access(1'b0, 2'd2, a, '0, 1'b0);
        do_access(1'b0, 2'd2, b, '0, 1'b0);
        do_access(1'b0, 2'd2, a, '0, 1'b0);
    endtask

    task automatic uncached_reads(input word_t c);
        do_access(1'b1, 2'd2, c, lcg_next(), 1'b0);
        do_access(1'b0, 2'd2, c, '0, 1'b0);
        do_access(1'b0, 2'd2, c, '0, 1'b1);
        do_access(1'b0, 2'd2, c, '0, 1'b0);
    endtask

    task automatic exception_guard(input word_t x, input word_t y);
        do_access(1'b1, 2'd2, x, lcg_next(), 1'b0);
        do_access(1'b1, 2'd2, y, lcg_next(), 1'b0);
        pulse_except();
        do_access(1'b0, 2'd2, x, '0, 1'b0);
        do_access(1'b0, 2'd2, y, '0, 1'b0);
        do_access(1'b0, 2'd2, x, '0, 1'b0);
        do_access(1'b0, 2'd2, y, '0, 1'b0);
        do_access(1'b0, 2'd2, x, '0, 1'b0);
        do_access(1'b0, 2'd2, y, '0, 1'b0);
    endtask

    // 4 tags by 16 indexes, so lines keep colliding
    function automatic word_t window_addr(input logic [1:0] t, input logic [3:0] i,
                                          input logic [1:0] off);
        return {18'd0, t, 6'b001000, i, off};
    endfunction

    task automatic random_mix(input int count);
        logic [31:0] r;
        logic [1:0] off;
        size_t size;
        word_t addr;
        for (int k = 0; k < 64; k++) begin
            do_access(1'b1, 2'd2, window_addr(k[5:4], k[3:0], 2'b00), lcg_next(), 1'b0);
        end
        for (int n = 0; n < count; n++) begin
            r = lcg_next();
            off = r[15:14];
            size = (r[17:16] == 2'd3) ? 2'd2 : r[17:16];
            if (size == 2'd1) begin
                off[0] = 1'b0;
            end else if (size == 2'd2) begin
                off = 2'b00;
            end
            addr = window_addr(r[9:8], r[13:10], off);
            if (r[20:18] < 3'd3) begin
                do_access(1'b1, size, addr, lcg_next(), r[23:21] == 3'd0);
            end else begin
                do_access(1'b0, 2'd2, addr, '0, r[23:21] == 3'd0);
            end
            if (r[26:24] == 3'd0) begin
                idle_cycles(1);
            end
        end
    endtask

    // latency counts falling edges from the request cycle
    always @(negedge clk) begin
        if (!rst && cpu_req) begin
            if (cpu_addr_ok) begin
                addr_ok_cnt = addr_ok_cnt + 1;
            end
            if (!cpu_data_ok) begin
                lat_cnt = lat_cnt + 1;
            end else if (exp_lat_q.size() == 0) begin
                report_fail("cpu_data_ok came with no access outstanding");
            end else begin
                chk_lat = exp_lat_q.pop_front();
                chk_data = exp_chk_q.pop_front();
                chk_word = exp_data_q.pop_front();
                assert (lat_cnt == chk_lat) else begin
                    report_fail($sformatf(
                        "** Error: cpu_data_ok latency 0x%0h, expected 0x%0h at %h",
                        lat_cnt, chk_lat, cpu_addr));
                end
                // one address strobe per access, so a hit has it in the request cycle
                assert (addr_ok_cnt == 1) else begin
                    report_fail($sformatf(
                        "** Error: cpu_addr_ok pulses 0x%0h, expected 0x1 at %h",
                        addr_ok_cnt, cpu_addr));
                end
                if (chk_data) begin
                    assert (cpu_rdata === chk_word) else begin
                        report_fail($sformatf("** Error: cpu_rdata 0x%h, expected 0x%h at %h",
                                              cpu_rdata, chk_word, cpu_addr));
                    end
                end
                lat_cnt = 0;
                addr_ok_cnt = 0;
            end
        end else if (!rst && (cpu_data_ok || cpu_addr_ok)) begin
            report_fail("cpu_data_ok or cpu_addr_ok high while cpu_req is low");
        end
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        cpu_req = 1'b0;
        cpu_wr = 1'b0;
        cpu_size = 2'd0;
        cpu_addr = '0;
        cpu_wdata = '0;
        no_dcache = 1'b0;
        data_except = 1'b0;
        lcg_state = 32'ha6be;
        guard_left = 0;
        lat_cnt = 0;
        addr_ok_cnt = 0;
        for (int k = 0; k < cache_depth; k++) begin
            ref_valid[k] = 1'b0;
        end
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        write_then_read(32'h0000_0040);
        partial_lane_writes(32'h0000_0080, 32'h0000_00c0);
        conflict_eviction(32'h0000_0100, 32'h0000_1100);
        uncached_reads(32'h0000_0140);
        exception_guard(32'h0000_0180, 32'h0000_01c0);
        random_mix(2000);
        idle_cycles(2);
        if (exp_lat_q.size() == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("%0d accesses ended without a cpu_data_ok check", exp_lat_q.size());
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
